/* vlog.f */
design/ecc_pkg.sv
design/ecc_parity_gen.sv
design/ecc_syndrome_stage.sv
design/ecc_correct_stage.sv
design/ecc_118_top.sv
tests/ecc_118_props.sv
tests/ecc_118_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ECC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ecc_118_tb -f vlog.f \
    --Mdir obj_dir -o ecc_118_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/ecc_118_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* tests/ecc_118_tb.sv */
`timescale 1ns/1ps

module ecc_118_tb
    import ecc_pkg::*;
();

    localparam int          CLK_HALF     = 20;
    localparam int          CLK_PERIOD   = 2 * CLK_HALF;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_SLOTS    = 600;
    localparam int          CODE_W       = DATA_W + PARITY_W;
    localparam int          TIMEOUT_NS   = (NUM_SLOTS + 20 + RESET_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'hb62a_ba33;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    data_t   data_in;
    parity_t parity_in;
    logic    bypass;
    logic    out_valid;
    data_t   data_out;
    parity_t parity_out;
    logic    sbit_err;
    logic    dbit_err;

    logic [31:0] lfsr_state;
    parity_t     col_table [DATA_W];
    int          cyc = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    // Expected words in flight, oldest first
    data_t   exp_data_q[$];
    parity_t exp_parity_q[$];
    logic    exp_sbit_q[$];
    logic    exp_dbit_q[$];
    int      exp_edge_q[$];

    int n_clean = 0;
    int n_single_data = 0;
    int n_single_check = 0;
    int n_double = 0;
    int n_bypass = 0;

    ecc_118_top i_ecc_118_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ******************************
    // Random source
    // ******************************

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic next_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    function automatic data_t rand_data();
        data_t d;
        for (int i = 0; i < DATA_W; i++) begin
            d[i] = next_bit();
        end
        return d;
    endfunction

    // ******************************
    // Reference model
    // ******************************

    // Non powers of two from 3 up, top bit for odd weight
    task automatic build_columns();
        int unsigned v;
        int          n;
        logic [6:0]  low;
        v = 3;
        n = 0;
        while (n < DATA_W) begin
            if ($countones(v) != 1) begin
                low = v[6:0];
                col_table[n] = {~^low, low};
                n++;
            end
            v++;
        end
    endtask

    function automatic parity_t encode(input data_t d);
        parity_t p;
        p = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (d[i]) begin
                p = p ^ col_table[i];
            end
        end
        return p;
    endfunction

    task automatic flip_bit(input int unsigned pos, inout data_t d, inout parity_t p);
        if (pos < DATA_W) begin
            d[pos] = ~d[pos];
        end else begin
            p[pos - DATA_W] = ~p[pos - DATA_W];
        end
    endtask

    // ******************************
    // Compare tasks
    // ******************************

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_parity(input string name, input parity_t exp, input parity_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // ******************************
    // Stimulus
    // ******************************

    task automatic drive_slot();
        data_t       sent;
        data_t       rx_data;
        parity_t     rx_parity;
        int unsigned n_err;
        int unsigned pos0;
        int unsigned pos1;
        logic        byp;
        data_t       e_data;
        logic        e_sbit;
        logic        e_dbit;
        if (rand_bits(2) == 0) begin
            in_valid = 1'b0;
        end else begin
            sent  = rand_data();
            n_err = rand_bits(2);
            if (n_err == 3) begin
                n_err = 0;
            end
            pos0 = rand_bits(7) % CODE_W;
            pos1 = pos0;
            while (pos1 == pos0) begin
                pos1 = rand_bits(7) % CODE_W;
            end
            byp = (rand_bits(3) == 0);

            rx_data   = sent;
            rx_parity = encode(sent);
            if (n_err >= 1) begin
                flip_bit(pos0, rx_data, rx_parity);
            end
            if (n_err == 2) begin
                flip_bit(pos1, rx_data, rx_parity);
            end

            if (byp) begin
                e_data = rx_data;
                e_sbit = 1'b0;
                e_dbit = 1'b0;
                n_bypass++;
            end else if (n_err == 0) begin
                e_data = sent;
                e_sbit = 1'b0;
                e_dbit = 1'b0;
                n_clean++;
            end else if (n_err == 1) begin
                e_data = sent;
                e_sbit = 1'b1;
                e_dbit = 1'b0;
                if (pos0 < DATA_W) n_single_data++;
                else n_single_check++;
            end else begin
                e_data = rx_data;
                e_sbit = 1'b0;
                e_dbit = 1'b1;
                n_double++;
            end

            in_valid  = 1'b1;
            data_in   = rx_data;
            parity_in = rx_parity;
            bypass    = byp;

            exp_data_q.push_back(e_data);
            exp_parity_q.push_back(encode(rx_data));
            exp_sbit_q.push_back(e_sbit);
            exp_dbit_q.push_back(e_dbit);
            // Sampled at the next edge, seen at the negedge two edges on
            exp_edge_q.push_back(cyc + 2);
        end
    endtask

    // ******************************
    // Output monitor
    // ******************************

    always @(negedge clk) begin : output_monitor
        data_t   e_data;
        parity_t e_parity;
        logic    e_sbit;
        logic    e_dbit;
        int      e_edge;
        if (rst_n && out_valid) begin
            if (exp_data_q.size() == 0) begin
                other_errors++;
                $display("Unexpected out_valid at %0t with no word in flight", $time);
            end else begin
                e_data   = exp_data_q.pop_front();
                e_parity = exp_parity_q.pop_front();
                e_sbit   = exp_sbit_q.pop_front();
                e_dbit   = exp_dbit_q.pop_front();
                e_edge   = exp_edge_q.pop_front();
                check_data("data_out", e_data, data_out);
                check_parity("parity_out", e_parity, parity_out);
                check_flag("sbit_err", e_sbit, sbit_err);
                check_flag("dbit_err", e_dbit, dbit_err);
                if (cyc != e_edge) begin
                    other_errors++;
                    $display("Word left at cycle %0d instead of cycle %0d", cyc, e_edge);
                end
            end
        end else if (out_valid !== 1'b0 || sbit_err !== 1'b0 || dbit_err !== 1'b0) begin
            other_errors++;
            $display("out_valid or an error flag is not low at %0t", $time);
        end
    end

    initial begin : stimulus
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        lfsr_state = SEED;
        build_columns();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;

        for (int s = 0; s < NUM_SLOTS; s++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_slot();
        end
        @(posedge clk);
        #DRIVE_DELAY in_valid = 1'b0;

        while (exp_data_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        if (n_clean == 0 || n_single_data == 0 || n_single_check == 0 ||
            n_double == 0 || n_bypass == 0) begin
            other_errors++;
            $display("Random stimulus did not reach every error case");
        end

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #TIMEOUT_NS;
        $display("Watchdog expired with %0d words still outstanding", exp_data_q.size());
        $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
        $display("test failed");
        $finish;
    end

endmodule

/* tests/ecc_118_props.sv */
`timescale 1ns/1ps

module ecc_118_props
    import ecc_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic bypass,
    input logic out_valid,
    input logic sbit_err,
    input logic dbit_err
);

    // Bypass of the words held in the two stages
    logic byp_s1;
    logic byp_s2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byp_s1 <= 1'b0;
            byp_s2 <= 1'b0;
        end else begin
            byp_s1 <= in_valid && bypass;
            byp_s2 <= byp_s1;
        end
    end

    // ******************************
    // Output timing and flags
    // ******************************

    a_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 2)
    ) else $error("out_valid does not follow in_valid by two cycles");

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(sbit_err && dbit_err)
    ) else $error("sbit_err and dbit_err are high together");

    a_flags_qualified: assert property (
        @(posedge clk) disable iff (!rst_n) (!out_valid || byp_s2) |-> (!sbit_err && !dbit_err)
    ) else $error("Error flag high without a checked output word");

endmodule

bind ecc_118_top ecc_118_props i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .bypass    (bypass),
    .out_valid (out_valid),
    .sbit_err  (sbit_err),
    .dbit_err  (dbit_err)
);

/* design/ecc_118_top.sv */
`timescale 1ns/1ps

module ecc_118_top
    import ecc_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    in_valid,
    input  data_t   data_in,
    input  parity_t parity_in,
    input  logic    bypass,

    output logic    out_valid,
    output data_t   data_out,
    output parity_t parity_out,
    output logic    sbit_err,
    output logic    dbit_err
);

    logic      s1_valid;
    data_t     s1_data;
    parity_t   s1_parity;
    syndrome_t s1_syndrome;
    logic      s1_bypass;

    // ******************************
    // Stage 1, encode and syndrome
    // ******************************

    ecc_syndrome_stage i_syndrome_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .data_in     (data_in),
        .parity_in   (parity_in),
        .bypass      (bypass),
        .s1_valid    (s1_valid),
        .s1_data     (s1_data),
        .s1_parity   (s1_parity),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass)
    );

    // ******************************
    // Stage 2, decode and correct
    // ******************************

    ecc_correct_stage i_correct_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .s1_valid    (s1_valid),
        .s1_data     (s1_data),
        .s1_parity   (s1_parity),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass),
        .out_valid   (out_valid),
        .data_out    (data_out),
        .parity_out  (parity_out),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err)
    );

endmodule

/* design/ecc_correct_stage.sv */
`timescale 1ns/1ps

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      s1_valid,
    input  data_t     s1_data,
    input  parity_t   s1_parity,
    input  syndrome_t s1_syndrome,
    input  logic      s1_bypass,

    output logic      out_valid,
    output data_t     data_out,
    output parity_t   parity_out,
    output logic      sbit_err,
    output logic      dbit_err
);

    data_t      flip_mask;
    logic       data_hit;
    logic       check_hit;
    err_class_t err_class;
    data_t      corrected;
    logic       sbit_next;
    logic       dbit_next;

    // ******************************
    // Syndrome decode
    // ******************************

    // A data bit is in error when the syndrome is its column
    for (genvar i = 0; i < DATA_W; i++) begin : g_flip
        localparam parity_t COL = ecc_column(i);

        assign flip_mask[i] = (s1_syndrome == COL);
    end

    assign data_hit = |flip_mask;

    // One-hot syndrome means a check bit itself flipped
    assign check_hit = (s1_syndrome != '0) &&
                       ((s1_syndrome & (s1_syndrome - 1'b1)) == '0);

    always_comb begin
        if (s1_syndrome == '0) begin
            err_class = ERR_NONE;
        end else if (data_hit || check_hit) begin
            err_class = ERR_SINGLE;
        end else begin
            err_class = ERR_DOUBLE;
        end
    end

    // ******************************
    // Correction and flags
    // ******************************

    // Mask is all zero for check-bit and double errors
    assign corrected = s1_bypass ? s1_data : (s1_data ^ flip_mask);

    assign sbit_next = s1_valid && !s1_bypass && (err_class == ERR_SINGLE);
    assign dbit_next = s1_valid && !s1_bypass && (err_class == ERR_DOUBLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            sbit_err  <= sbit_next;
            dbit_err  <= dbit_next;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            data_out   <= corrected;
            parity_out <= s1_parity;
        end
    end

endmodule

/* design/ecc_syndrome_stage.sv */
`timescale 1ns/1ps

module ecc_syndrome_stage
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      in_valid,
    input  data_t     data_in,
    input  parity_t   parity_in,
    input  logic      bypass,

    output logic      s1_valid,
    output data_t     s1_data,
    output parity_t   s1_parity,
    output syndrome_t s1_syndrome,
    output logic      s1_bypass
);

    parity_t   gen_parity;
    syndrome_t syndrome;

    // ******************************
    // Encode and compare
    // ******************************

    ecc_parity_gen i_parity_gen (
        .data   (data_in),
        .parity (gen_parity)
    );

    // Zero when the stored check bits agree with the word
    assign syndrome = parity_in ^ gen_parity;

    // ******************************
    // Stage 1 registers
    // ******************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // Payload only moves with a valid word
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_data     <= data_in;
            s1_parity   <= gen_parity;
            s1_syndrome <= syndrome;
            s1_bypass   <= bypass;
        end
    end

endmodule

/* design/ecc_parity_gen.sv */
`timescale 1ns/1ps

module ecc_parity_gen
    import ecc_pkg::*;
(
    input  data_t   data,
    output parity_t parity
);

    // Data bits that feed check bit k
    function automatic data_t check_mask(input int unsigned k);
        data_t   mask;
        parity_t col;
        mask = '0;
        for (int unsigned i = 0; i < DATA_W; i++) begin
            col = ecc_column(i);
            mask[i] = col[k];
        end
        return mask;
    endfunction

    // ******************************
    // One XOR tree per check bit
    // ******************************

    for (genvar k = 0; k < PARITY_W; k++) begin : g_check
        localparam data_t MASK = check_mask(k);

        assign parity[k] = ^(data & MASK);
    end

endmodule

/* design/ecc_pkg.sv */
package ecc_pkg;

    // ******************************
    // Code geometry
    // ******************************

    localparam int DATA_W    = 118;
    localparam int PARITY_W  = 8;
    // Check bits below the overall parity bit
    localparam int HAMMING_W = PARITY_W - 1;

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [PARITY_W-1:0] parity_t;
    typedef logic [PARITY_W-1:0] syndrome_t;

    typedef enum logic [1:0] {
        ERR_NONE   = 2'b00,
        ERR_SINGLE = 2'b01,
        ERR_DOUBLE = 2'b10
    } err_class_t;

    // ******************************
    // Column code of a data bit
    // ******************************

    // Low bits walk the values 3, 5, 6, 7, 9, ... skipping powers of two,
    // so no data column can alias a single check-bit error.
    // Top bit makes every column odd weight, which keeps any two-bit
    // error at an even, nonzero syndrome.
    function automatic parity_t ecc_column(input int unsigned idx);
        int unsigned           cnt;
        logic [HAMMING_W-1:0]  code;
        cnt  = 0;
        code = '0;
        for (int unsigned v = 3; v < 2**HAMMING_W; v++) begin
            if ((v & (v - 1)) != 0) begin
                if (cnt == idx) begin
                    code = HAMMING_W'(v);
                end
                cnt++;
            end
        end
        return {~^code, code};
    endfunction

endpackage
